// File: hw/vsldu_pkg.sv
// Slide unit shared definitions
// Widths, opcode/SEW/LMUL encodings and the request and control structs.
`default_nettype none

package vsldu_pkg;

    localparam int VLEN       = 128;              // bits per vector register
    localparam int GROUP_REGS = 4;                // registers in widest group
    localparam int GROUP_W    = VLEN * GROUP_REGS;
    localparam int SCALAR_W   = 32;               // widest element
    localparam int OFFSET_W   = 7;                // slide offset bits from rs1

    typedef logic [VLEN-1:0] vreg_t;
    typedef vreg_t [GROUP_REGS-1:0] vgroup_t;     // reg 0 in low bits

    typedef enum logic [2:0] {
        OP_NONE       = 3'd0,
        OP_SLIDE1UP   = 3'd1,
        OP_SLIDEUP    = 3'd2,
        OP_SLIDE1DOWN = 3'd3,
        OP_SLIDEDOWN  = 3'd4,
        OP_VMV        = 3'd5
    } vsldu_op_e;

    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2
    } sew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2
    } lmul_e;

    typedef struct packed {
        vsldu_op_e             op;
        sew_e                  sew;
        lmul_e                 lmul;
        logic [SCALAR_W-1:0]   rs1;
    } vsldu_req_t;

    // decoded controls shared by both shifters and writeback
    typedef struct packed {
        logic [$clog2(SCALAR_W):0] elem_w;        // 8, 16 or 32
        logic [$clog2(GROUP_W):0]  group_w;       // 128, 256 or 512
        logic [OFFSET_W-1:0]       shift_elems;
        logic [SCALAR_W-1:0]       scalar;        // masked to elem_w
        logic                      scalar_fill;
        logic                      up_overflow;
        logic                      down_overflow;
        logic                      op_valid;
    } vsldu_ctrl_t;

endpackage

`default_nettype wire

// File: hw/vsldu_decode.sv
// Slide unit decode
// Maps SEW/LMUL to widths, picks the shift count and flags offsets that
// run past the full register field or past the active group.
`default_nettype none

module vsldu_decode import vsldu_pkg::*; (
    input  vsldu_req_t  req,
    output vsldu_ctrl_t ctrl
);

    logic [1:0]          sew_sh;      // log2(elem_w / 8)
    logic [1:0]          lmul_sh;     // log2(group_w / 128)
    logic [OFFSET_W-1:0] full_cnt;
    logic [OFFSET_W-1:0] grp_cnt;

    always_comb begin
        case (req.sew)
            SEW_16: begin
                sew_sh      = 2'd1;
                ctrl.elem_w = 6'd16;
                ctrl.scalar = {16'b0, req.rs1[15:0]};
            end
            SEW_32: begin
                sew_sh      = 2'd2;
                ctrl.elem_w = 6'd32;
                ctrl.scalar = req.rs1;
            end
            default: begin                       // 8 bit and unsupported codes
                sew_sh      = 2'd0;
                ctrl.elem_w = 6'd8;
                ctrl.scalar = {24'b0, req.rs1[7:0]};
            end
        endcase

        case (req.lmul)
            LMUL_2:  lmul_sh = 2'd1;
            LMUL_4:  lmul_sh = 2'd2;
            default: lmul_sh = 2'd0;             // single register
        endcase
        ctrl.group_w = 10'(VLEN) << lmul_sh;

        case (req.op)
            OP_SLIDE1UP, OP_SLIDE1DOWN: begin
                ctrl.shift_elems = OFFSET_W'(1);
                ctrl.scalar_fill = 1'b1;
                ctrl.op_valid    = 1'b1;
            end
            OP_SLIDEUP, OP_SLIDEDOWN, OP_VMV: begin
                ctrl.shift_elems = req.rs1[OFFSET_W-1:0];
                ctrl.scalar_fill = 1'b0;
                ctrl.op_valid    = 1'b1;
            end
            default: begin                       // idle and codes 6, 7
                ctrl.shift_elems = req.rs1[OFFSET_W-1:0];
                ctrl.scalar_fill = 1'b0;
                ctrl.op_valid    = 1'b0;
            end
        endcase

        // element counts of 512 bits and of the group
        full_cnt = OFFSET_W'(64) >> sew_sh;
        grp_cnt  = (OFFSET_W'(16) << lmul_sh) >> sew_sh;

        ctrl.up_overflow   = ctrl.shift_elems >= full_cnt;
        ctrl.down_overflow = ctrl.shift_elems >= grp_cnt;
    end

endmodule

`default_nettype wire

// File: hw/vsldu_up_shifter.sv
// Slide-up datapath
// Moves vs2 up by the element count; vacated low elements come from the
// old destination, or from the scalar for slide-up-by-one.
`default_nettype none

module vsldu_up_shifter import vsldu_pkg::*; (
    input  vsldu_ctrl_t ctrl,
    input  vgroup_t     vs2,
    input  vgroup_t     vd_old,
    output vgroup_t     up_result
);

    logic [12:0]        shift_bits;   // up to 127 * 32
    logic [GROUP_W-1:0] shifted;
    logic [GROUP_W-1:0] low_mask;
    logic [GROUP_W-1:0] fill;
    logic [GROUP_W-1:0] scalar_ext;

    assign shift_bits = ctrl.shift_elems * ctrl.elem_w;

    assign shifted  = vs2 << shift_bits;
    assign low_mask = ~({GROUP_W{1'b1}} << shift_bits);   // vacated bits

    assign scalar_ext = {{(GROUP_W-SCALAR_W){1'b0}}, ctrl.scalar};

    // scalar is already masked to one element
    assign fill = ctrl.scalar_fill ? scalar_ext : GROUP_W'(vd_old);

    always_comb begin
        if (ctrl.up_overflow) begin
            up_result = vd_old;                // whole field kept
        end else begin
            up_result = shifted | (fill & low_mask);
        end
    end

endmodule

`default_nettype wire

// File: hw/vsldu_down_shifter.sv
// Slide-down datapath
// Moves vs2 down inside the LMUL group with zero fill; slide-down-by-one
// drops the scalar into the top element of the group.
`default_nettype none

module vsldu_down_shifter import vsldu_pkg::*; (
    input  vsldu_ctrl_t ctrl,
    input  vgroup_t     vs2,
    output vgroup_t     down_result
);

    logic [12:0]                   shift_bits;
    logic [$bits(ctrl.group_w)-1:0] top_pos;     // lsb of top element
    logic [GROUP_W-1:0]            group_mask;
    logic [GROUP_W-1:0]            in_group;
    logic [GROUP_W-1:0]            shifted;
    logic [GROUP_W-1:0]            top_fill;

    assign shift_bits = ctrl.shift_elems * ctrl.elem_w;

    // a shift by 512 gives zero, so the full group keeps every bit
    assign group_mask = ~({GROUP_W{1'b1}} << ctrl.group_w);
    assign in_group   = vs2 & group_mask;
    assign shifted    = in_group >> shift_bits;

    assign top_pos  = ctrl.group_w - ctrl.elem_w;
    assign top_fill = {{(GROUP_W-SCALAR_W){1'b0}}, ctrl.scalar} << top_pos;

    always_comb begin
        if (ctrl.down_overflow) begin
            down_result = '0;
        end else if (ctrl.scalar_fill) begin
            down_result = shifted | top_fill;  // top element already zero
        end else begin
            down_result = shifted;
        end
    end

endmodule

`default_nettype wire

// File: hw/vsldu_writeback.sv
// Slide unit result stage
// Selects the operation result, builds the scalar move and registers
// result and done one cycle after the request.
`default_nettype none

module vsldu_writeback import vsldu_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  vsldu_op_e   op,
    input  vsldu_ctrl_t ctrl,
    input  vgroup_t     up_result,
    input  vgroup_t     down_result,
    output vgroup_t     result,
    output logic        done
);

    vgroup_t result_d;

    always_comb begin
        case (op)
            OP_SLIDE1UP, OP_SLIDEUP: begin
                result_d = up_result;
            end
            OP_SLIDE1DOWN, OP_SLIDEDOWN: begin
                result_d = down_result;
            end
            OP_VMV: begin
                result_d = {{(GROUP_W-SCALAR_W){1'b0}}, ctrl.scalar};
            end
            default: begin
                result_d = result;             // not loaded anyway
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= ctrl.op_valid;
            if (ctrl.op_valid) begin
                result <= result_d;            // holds on idle cycles
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vsldu_top.sv
// Vector slide unit
// Decode feeds the up and down shifters; writeback registers the
// selected result with a one-cycle done.
`default_nettype none

module vsldu_top import vsldu_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  vsldu_req_t req,
    input  vgroup_t    vs2,
    input  vgroup_t    vd_old,
    output vgroup_t    result,
    output logic       done
);

    vsldu_ctrl_t ctrl;
    vgroup_t     up_result;
    vgroup_t     down_result;

    vsldu_decode u_decode (
        .req  (req),
        .ctrl (ctrl)
    );

    vsldu_up_shifter u_up_shifter (
        .ctrl      (ctrl),
        .vs2       (vs2),
        .vd_old    (vd_old),
        .up_result (up_result)
    );

    vsldu_down_shifter u_down_shifter (
        .ctrl        (ctrl),
        .vs2         (vs2),
        .down_result (down_result)
    );

    vsldu_writeback u_writeback (
        .clk         (clk),
        .nrst        (nrst),
        .op          (req.op),       // opcode only used for selection here
        .ctrl        (ctrl),
        .up_result   (up_result),
        .down_result (down_result),
        .result      (result),
        .done        (done)
    );

endmodule

`default_nettype wire

// File: tests/vsldu_model.svh
// Slide unit reference model
// Computes the expected result of one request element by element from
// the slide, scalar-fill and group rules of the unit.
`ifndef VSLDU_MODEL_SVH
`define VSLDU_MODEL_SVH
`default_nettype none

// element width in bits with unsupported codes as 8
function automatic int unsigned sew_bits(input logic [2:0] code);
    case (code)
        3'd1:    return 16;
        3'd2:    return 32;
        default: return 8;
    endcase
endfunction

// group width in bits with unsupported codes as one register
function automatic int unsigned group_bits(input logic [2:0] code);
    case (code)
        3'd1:    return 2 * VLEN;
        3'd2:    return 4 * VLEN;
        default: return VLEN;
    endcase
endfunction

function automatic logic [31:0] width_mask(input int unsigned ew);
    return (ew >= 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
endfunction

function automatic logic [31:0] get_elem(input logic [GROUP_W-1:0] v,
                                         input int unsigned idx, input int unsigned ew);
    logic [GROUP_W-1:0] s;
    s = v >> (idx * ew);
    return s[31:0] & width_mask(ew);
endfunction

// ors one element into a vector whose slot is still zero
function automatic logic [GROUP_W-1:0] put_elem(input logic [GROUP_W-1:0] v,
                                                input int unsigned idx, input int unsigned ew,
                                                input logic [31:0] val);
    logic [GROUP_W-1:0] w;
    w = {{(GROUP_W-32){1'b0}}, val & width_mask(ew)};
    return v | (w << (idx * ew));
endfunction

function automatic vgroup_t expected_result(input vsldu_req_t rq, input vgroup_t v2,
                                            input vgroup_t vold);
    int unsigned        ew;
    int unsigned        n_full;
    int unsigned        n_grp;
    int unsigned        k;
    logic [31:0]        sc;
    logic [GROUP_W-1:0] r;
    ew     = sew_bits(rq.sew);
    n_full = GROUP_W / ew;
    n_grp  = group_bits(rq.lmul) / ew;
    k      = rq.rs1[OFFSET_W-1:0];
    sc     = rq.rs1 & width_mask(ew);          // upper scalar bits dropped
    r      = '0;
    case (rq.op)
        OP_SLIDEUP: begin
            if (k >= n_full) begin
                r = vold;
            end else begin
                for (int i = 0; i < n_full; i++) begin
                    if (i < k) begin
                        r = put_elem(r, i, ew, get_elem(vold, i, ew));
                    end else begin
                        r = put_elem(r, i, ew, get_elem(v2, i - k, ew));
                    end
                end
            end
        end
        OP_SLIDE1UP: begin
            r = put_elem(r, 0, ew, sc);
            for (int i = 1; i < n_full; i++) begin
                r = put_elem(r, i, ew, get_elem(v2, i - 1, ew));
            end
        end
        OP_SLIDEDOWN: begin
            for (int i = 0; i + k < n_grp; i++) begin     // empty when k >= n_grp
                r = put_elem(r, i, ew, get_elem(v2, i + k, ew));
            end
        end
        OP_SLIDE1DOWN: begin
            for (int i = 0; i + 1 < n_grp; i++) begin
                r = put_elem(r, i, ew, get_elem(v2, i + 1, ew));
            end
            r = put_elem(r, n_grp - 1, ew, sc);
        end
        OP_VMV: begin
            r = put_elem(r, 0, ew, sc);
        end
        default: begin
            r = '0;
        end
    endcase
    return r;
endfunction

`default_nettype wire
`endif

// File: tests/vsldu_tb.sv
// Slide unit testbench
// Directed and random requests against the reference model, checking
// result and done one cycle after each request.
`default_nettype none

module vsldu_tb import vsldu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h461a_cddd;
    localparam int N_RESET    = 3;
    localparam int N_DIRECTED = 130;               // incl. idle cycles after reset
    localparam int N_RANDOM   = 400;
    localparam int N_TAIL     = 16;
    localparam int PLANNED_CYCLES = N_RESET + N_DIRECTED + N_RANDOM + N_TAIL;

    logic       clk;
    logic       nrst;
    vsldu_req_t req;
    vgroup_t    vs2;
    vgroup_t    vd_old;
    vgroup_t    result;
    logic       done;

    logic    done_q[$];                            // one entry per driven cycle
    vgroup_t exp_q[$];                             // valid ops only
    vgroup_t prev_result;
    int      done_errors;
    int      result_errors;

    vsldu_top u_vsldu_top (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .vs2    (vs2),
        .vd_old (vd_old),
        .result (result),
        .done   (done)
    );

    always #2 clk = ~clk;

    function automatic vgroup_t rand_group();
        logic [GROUP_W-1:0] v;
        for (int i = 0; i < GROUP_W / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    task automatic issue(input logic [2:0] op, input logic [2:0] sew, input logic [2:0] lmul,
                         input logic [31:0] rs1, input vgroup_t a, input vgroup_t old);
        vsldu_req_t rq;
        @(negedge clk);
        rq.op   = vsldu_op_e'(op);
        rq.sew  = sew_e'(sew);
        rq.lmul = lmul_e'(lmul);
        rq.rs1  = rs1;
        req     = rq;
        vs2     = a;
        vd_old  = old;
        if (op >= 3'd1 && op <= 3'd5) begin
            exp_q.push_back(expected_result(rq, a, old));
            done_q.push_back(1'b1);
        end else begin
            done_q.push_back(1'b0);                // idle or invalid code
        end
    endtask

    task automatic slide_up_offsets();
        int n;
        int offs[5];
        for (int s = 0; s < 8; s++) begin
            n    = GROUP_W / sew_bits(3'(s));
            offs = '{0, n / 2, n - 1, n, 127};
            foreach (offs[j]) begin
                issue(OP_SLIDEUP, 3'(s), 3'($urandom_range(0, 3)),
                      ($urandom & 32'hffff_ff80) | 32'(offs[j]), rand_group(), rand_group());
            end
        end
    endtask

    task automatic scalar_fill_up_and_move();
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < 2; r++) begin
                issue(OP_SLIDE1UP, 3'(s), 3'(r), $urandom | 32'hf0f0_0000,
                      rand_group(), rand_group());
                issue(OP_VMV, 3'(s), 3'(r), $urandom | 32'hf0f0_0000,
                      rand_group(), rand_group());
            end
        end
    endtask

    task automatic down_offsets_per_group();
        int n;
        int offs[5];
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 4; l++) begin              // code 3 is unsupported
                n    = group_bits(3'(l)) / sew_bits(3'(s));
                offs = '{0, n / 2, n - 1, n, 127};
                foreach (offs[j]) begin
                    issue(OP_SLIDEDOWN, 3'(s), 3'(l),
                          ($urandom & 32'hffff_ff80) | 32'(offs[j]), rand_group(), rand_group());
                end
            end
        end
    endtask

    task automatic top_fill_per_group();
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 4; l++) begin
                issue(OP_SLIDE1DOWN, 3'(s), 3'(l), $urandom, rand_group(), rand_group());
            end
        end
    endtask

    task automatic mixed_stream();
        logic [31:0] rs1;
        for (int i = 0; i < N_RANDOM; i++) begin
            rs1 = $urandom;
            if ($urandom_range(0, 3) != 0) begin
                rs1[6:0] = 7'($urandom_range(0, 63));  // mostly in-range offsets
            end
            issue(3'($urandom_range(0, 7)), 3'($urandom_range(0, 4)),
                  3'($urandom_range(0, 4)), rs1, rand_group(), rand_group());
        end
    endtask

    // result and done one cycle after each driven request
    initial begin : compare
        logic    exp_done;
        vgroup_t exp_res;
        forever begin
            @(posedge clk);
            #1;
            if (done_q.size() > 0) begin
                exp_done = done_q.pop_front();
                exp_res  = prev_result;                 // idle keeps last value
                if (exp_done) begin
                    exp_res = exp_q.pop_front();
                end
                assert (done === exp_done) else begin
                    $display("[FAIL] %0t done expected %0b got %0b", $time, exp_done, done);
                    done_errors++;
                end
                assert (result === exp_res) else begin
                    $display("[FAIL] %0t result expected %h got %h", $time, exp_res, result);
                    result_errors++;
                end
                prev_result = exp_res;
            end
        end
    end

    initial begin : watchdog
        #(PLANNED_CYCLES * 4 + 200);
        $display("timeout: run did not finish within %0d cycles", PLANNED_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk           = 1'b0;
        nrst          = 1'b0;
        req           = '0;
        vs2           = '0;
        vd_old        = '0;
        prev_result   = '0;
        done_errors   = 0;
        result_errors = 0;

        repeat (N_RESET) @(negedge clk);
        nrst = 1'b1;
        assert (done === 1'b0) else begin
            $display("[FAIL] %0t done expected 0 got %0b", $time, done);
            done_errors++;
        end
        assert (result === '0) else begin
            $display("[FAIL] %0t result expected %h got %h", $time, vgroup_t'('0), result);
            result_errors++;
        end
        issue(OP_NONE, 3'd0, 3'd0, 32'd0, '0, '0);      // still zero before any request
        issue(OP_NONE, 3'd0, 3'd0, 32'd0, '0, '0);

        slide_up_offsets();
        scalar_fill_up_and_move();
        down_offsets_per_group();
        top_fill_per_group();
        mixed_stream();
        issue(OP_NONE, 3'd0, 3'd0, 32'd0, '0, '0);

        wait (done_q.size() == 0);
        @(negedge clk);

        $display("errors: done %0d, result %0d", done_errors, result_errors);
        if (done_errors + result_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

`include "vsldu_model.svh"

endmodule

`default_nettype wire

// File: vsldu.f
+incdir+tests
hw/vsldu_pkg.sv
hw/vsldu_decode.sv
hw/vsldu_up_shifter.sv
hw/vsldu_down_shifter.sv
hw/vsldu_writeback.sv
hw/vsldu_top.sv
tests/vsldu_tb.sv
